//--- all.f
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_refill.sv
hdl/icache_data_sram.sv
hdl/icache_fetch_out.sv
hdl/icache_top.sv
tb/axi_mem_model.sv
tb/icache_tb.sv

//--- hdl/icache_data_sram.sv
`timescale 1ns/1ps

module icache_data_sram (
	input  logic                  clk,
	input  logic                  ce,
	input  logic                  we,
	input  icache_pkg::row_addr_t row_addr,
	input  icache_pkg::row_t      wmask,
	input  icache_pkg::row_t      wdata,
	output icache_pkg::row_t      rdata
);
	import icache_pkg::*;

	// 64 rows of 128 bits, one per 16-byte slice of a line
	row_t mem_q [1 << ROW_AW];

	always_ff @(posedge clk) begin
		if (ce) begin
			if (we) begin
				// only bits with mask set are written
				mem_q[row_addr] <= (mem_q[row_addr] & ~wmask) | (wdata & wmask);
			end else begin
				// registered read, output holds when not enabled
				rdata <= mem_q[row_addr];
			end
		end
	end

endmodule

//--- hdl/icache_fetch_out.sv
`timescale 1ns/1ps

module icache_fetch_out (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  logic             lookup_fire,
	input  icache_pkg::way_t way_hit,
	input  logic [1:0]       word_sel,
	input  icache_pkg::row_t rdata0,
	input  icache_pkg::row_t rdata1,
	input  icache_pkg::row_t rdata2,
	input  icache_pkg::row_t rdata3,
	output logic [31:0]      inst,
	output logic             ready
);
	import icache_pkg::*;

	// way that hit in the lookup cycle, zero when nothing to return
	way_t way_q;
	// instruction slot within the row
	logic [1:0] word_q;

	row_t row_sel;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			// flush drops the pending result
			way_q <= '0;
			ready <= 1'b0;
		end else if (lookup_fire) begin
			way_q <= way_hit;
			ready <= 1'b1;
		end else begin
			way_q <= '0;
			ready <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_fire) begin
			word_q <= word_sel;
		end
	end

	// SRAM output is valid the cycle after the read, same as way_q
	always_comb begin
		case (way_q)
			4'b0001: row_sel = rdata0;
			4'b0010: row_sel = rdata1;
			4'b0100: row_sel = rdata2;
			4'b1000: row_sel = rdata3;
			default: row_sel = '0;
		endcase
	end

	assign inst = row_sel[word_q*INST_W +: INST_W];

endmodule

//--- hdl/icache_pkg.sv
package icache_pkg;

	// cache geometry, 4 ways x 16 sets x 64-byte lines
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int INDEX_W = 4;
	localparam int TAG_W = 22;

	// address split: tag is addr[31:10], set index is addr[9:6]
	localparam int TAG_LSB = 10;
	localparam int INDEX_LSB = 6;

	// per-way data SRAM, four rows per line, four instructions per row
	localparam int ROW_W = 128;
	localparam int ROW_AW = 6;

	// AXI refill, one line is eight 64-bit beats
	localparam int BEAT_W = 64;
	localparam int BEATS = 8;

	localparam int INST_W = 32;

	// read address channel constants
	// arlen is beats minus one
	localparam logic [7:0] AR_LEN = 8'd7;
	// 2^3 = 8 bytes per beat
	localparam logic [2:0] AR_SIZE = 3'd3;
	// INCR burst
	localparam logic [1:0] AR_BURST = 2'b01;

	// one bit per way, one-hot or all zero
	typedef logic [NUM_WAYS-1:0] way_t;

	typedef logic [TAG_W-1:0] tag_t;

	typedef logic [INDEX_W-1:0] index_t;

	typedef logic [ROW_W-1:0] row_t;

	// {set index, row within line}
	typedef logic [ROW_AW-1:0] row_addr_t;

endpackage

//--- hdl/icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [63:0]                   addr,
	input  logic                          valid,
	input  icache_pkg::way_t              way_hit,
	input  logic                          arready,
	input  logic [icache_pkg::BEAT_W-1:0] rdata,
	input  logic [1:0]                    rresp,
	input  logic                          rlast,
	input  logic                          rvalid,
	output logic [31:0]                   araddr,
	output logic [7:0]                    arlen,
	output logic [2:0]                    arsize,
	output logic [1:0]                    arburst,
	output logic                          arvalid,
	output logic                          rready,
	output logic                          lookup_fire,
	output logic                          hit_out,
	output icache_pkg::way_t              sram_ce,
	output icache_pkg::way_t              sram_we,
	output icache_pkg::row_addr_t         row_addr,
	output icache_pkg::row_t              wmask,
	output icache_pkg::row_t              wdata,
	output logic                          fill_we,
	output icache_pkg::way_t              fill_way,
	output icache_pkg::index_t            fill_index,
	output icache_pkg::tag_t              fill_tag
);
	import icache_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_REFILL
	} state_t;

	state_t state_q;
	state_t state_d;

	// beat number within the current burst
	logic [$clog2(BEATS)-1:0] beat_q;
	// rotating victim pointer, one-hot
	way_t victim_q;

	// set and tag of the line being fetched
	index_t miss_index_q;
	tag_t   miss_tag_q;

	logic idle;
	logic any_hit;
	logic ar_fire;
	logic beat_fire;

	assign idle    = (state_q == ST_IDLE);
	assign any_hit = (way_hit != '0);

	// read address channel, address is still combinational from the fetch side
	assign arvalid = idle && valid && !any_hit;
	assign araddr  = {addr[31:INDEX_LSB], {INDEX_LSB{1'b0}}};
	assign arlen   = AR_LEN;
	assign arsize  = AR_SIZE;
	assign arburst = AR_BURST;
	assign ar_fire = arvalid && arready;

	// data is always accepted, rresp is taken but not acted on
	assign rready    = 1'b1;
	assign beat_fire = !idle && rvalid;

	assign lookup_fire = idle && valid && any_hit;
	assign hit_out     = idle && any_hit;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (ar_fire) begin
					state_d = ST_REFILL;
				end
			end
			ST_REFILL: begin
				if (beat_fire && rlast) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= ST_IDLE;
			beat_q   <= '0;
			victim_q <= way_t'(1);
		end else begin
			state_q <= state_d;
			if (idle) begin
				beat_q <= '0;
				// pseudo-random replacement, advances each idle cycle
				victim_q <= {victim_q[NUM_WAYS-2:0], victim_q[NUM_WAYS-1]};
			end else if (beat_fire) begin
				// rvalid gaps simply stall the count
				beat_q <= beat_q + 1'b1;
			end
		end
	end

	// capture the miss line on address handshake
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			miss_index_q <= addr[INDEX_LSB +: INDEX_W];
			miss_tag_q   <= addr[TAG_LSB +: TAG_W];
		end
	end

	// idle reads the hitting way, refill writes the victim beat by beat
	assign sram_ce  = idle ? (valid ? way_hit : '0) : (beat_fire ? victim_q : '0);
	assign sram_we  = beat_fire ? victim_q : '0;
	assign row_addr = idle ? addr[TAG_LSB-1 -: ROW_AW]
		: {miss_index_q, beat_q[$clog2(BEATS)-1:1]};

	// even beat fills the low half of the row, odd beat the high half
	assign wmask = beat_q[0] ? {{BEAT_W{1'b1}}, {BEAT_W{1'b0}}}
		: {{BEAT_W{1'b0}}, {BEAT_W{1'b1}}};
	assign wdata = {rdata, rdata};

	// tag goes in with the last beat
	assign fill_we    = beat_fire && rlast;
	assign fill_way   = victim_q;
	assign fill_index = miss_index_q;
	assign fill_tag   = miss_tag_q;

	// an offered request stays up and unchanged until the memory side takes it
	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// memory side may only end a burst we asked for
	a_rlast_beat: assert property (@(posedge clk) disable iff (rst)
		rlast |-> rvalid && (state_q == ST_REFILL));

	// response code must at least be driven on every beat
	a_rresp_known: assert property (@(posedge clk) disable iff (rst)
		beat_fire |-> !$isunknown(rresp));

endmodule

//--- hdl/icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array (
	input  logic                clk,
	input  logic                rst,
	input  logic [63:0]         addr,
	input  logic                fill_we,
	input  icache_pkg::way_t    fill_way,
	input  icache_pkg::index_t  fill_index,
	input  icache_pkg::tag_t    fill_tag,
	input  logic                inv_valid,
	input  logic [63:0]         inv_addr,
	output icache_pkg::way_t    way_hit
);
	import icache_pkg::*;

	// lookup side fields
	index_t look_index;
	tag_t   look_tag;

	// snoop side fields
	index_t inv_index;
	tag_t   inv_tag;

	// valid bit per way and set
	logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
	// stored tags
	tag_t tag_q [NUM_WAYS][NUM_SETS];

	// ways whose line the snoop kills this cycle
	way_t inv_match;

	assign look_index = addr[INDEX_LSB +: INDEX_W];
	assign look_tag   = addr[TAG_LSB +: TAG_W];
	assign inv_index  = inv_addr[INDEX_LSB +: INDEX_W];
	assign inv_tag    = inv_addr[TAG_LSB +: TAG_W];

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			// four parallel comparators on the indexed set
			way_hit[w] = valid_q[w][look_index] && (tag_q[w][look_index] == look_tag);
			// snoop matches the stored tag, or the tag being filled right now
			// so a store racing the last beat still kills the new line
			inv_match[w] = inv_valid &&
				((tag_q[w][inv_index] == inv_tag) ||
				(fill_we && fill_way[w] && (fill_index == inv_index) &&
				(fill_tag == inv_tag)));
		end
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_we && fill_way[w]) begin
					valid_q[w][fill_index] <= 1'b1;
				end
				// later assignment, so invalidation beats a fill to the same entry
				if (inv_match[w]) begin
					valid_q[w][inv_index] <= 1'b0;
				end
			end
		end
	end

	// tag storage, only meaningful where valid is set
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill_we && fill_way[w]) begin
				tag_q[w][fill_index] <= fill_tag;
			end
		end
	end

	// a line is never allocated twice, so at most one way may match
	a_hit_onehot0: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit));

	// refill engine must name exactly one victim on a tag write
	a_fill_onehot: assert property (@(posedge clk) disable iff (rst)
		fill_we |-> $onehot(fill_way));

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [63:0] addr,
	input  logic        valid,
	input  logic        flush,
	input  logic        inv_valid,
	input  logic [63:0] inv_addr,
	output logic [31:0] inst,
	output logic        ready,
	output logic        hit_out,
	output logic [31:0] araddr,
	output logic [7:0]  arlen,
	output logic [2:0]  arsize,
	output logic [1:0]  arburst,
	output logic        arvalid,
	input  logic        arready,
	input  logic [63:0] rdata,
	input  logic [1:0]  rresp,
	input  logic        rlast,
	input  logic        rvalid,
	output logic        rready
);
	import icache_pkg::*;

	way_t way_hit;

	// tag update from the refill engine
	logic   fill_we;
	way_t   fill_way;
	index_t fill_index;
	tag_t   fill_tag;

	logic lookup_fire;

	// shared SRAM control, per-way enables
	way_t      sram_ce;
	way_t      sram_we;
	row_addr_t row_addr;
	row_t      wmask;
	row_t      wdata;

	row_t rdata0;
	row_t rdata1;
	row_t rdata2;
	row_t rdata3;

	icache_tag_array icache_tag_array_inst (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.fill_we    (fill_we),
		.fill_way   (fill_way),
		.fill_index (fill_index),
		.fill_tag   (fill_tag),
		.inv_valid  (inv_valid),
		.inv_addr   (inv_addr),
		.way_hit    (way_hit)
	);

	icache_refill icache_refill_inst (
		.clk         (clk),
		.rst         (rst),
		.addr        (addr),
		.valid       (valid),
		.way_hit     (way_hit),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.araddr      (araddr),
		.arlen       (arlen),
		.arsize      (arsize),
		.arburst     (arburst),
		.arvalid     (arvalid),
		.rready      (rready),
		.lookup_fire (lookup_fire),
		.hit_out     (hit_out),
		.sram_ce     (sram_ce),
		.sram_we     (sram_we),
		.row_addr    (row_addr),
		.wmask       (wmask),
		.wdata       (wdata),
		.fill_we     (fill_we),
		.fill_way    (fill_way),
		.fill_index  (fill_index),
		.fill_tag    (fill_tag)
	);

	// one data SRAM per way
	icache_data_sram way0_inst (
		.clk      (clk),
		.ce       (sram_ce[0]),
		.we       (sram_we[0]),
		.row_addr (row_addr),
		.wmask    (wmask),
		.wdata    (wdata),
		.rdata    (rdata0)
	);

	icache_data_sram way1_inst (
		.clk      (clk),
		.ce       (sram_ce[1]),
		.we       (sram_we[1]),
		.row_addr (row_addr),
		.wmask    (wmask),
		.wdata    (wdata),
		.rdata    (rdata1)
	);

	icache_data_sram way2_inst (
		.clk      (clk),
		.ce       (sram_ce[2]),
		.we       (sram_we[2]),
		.row_addr (row_addr),
		.wmask    (wmask),
		.wdata    (wdata),
		.rdata    (rdata2)
	);

	icache_data_sram way3_inst (
		.clk      (clk),
		.ce       (sram_ce[3]),
		.we       (sram_we[3]),
		.row_addr (row_addr),
		.wmask    (wmask),
		.wdata    (wdata),
		.rdata    (rdata3)
	);

	// word offset is addr[3:2], kept by the output side itself
	icache_fetch_out icache_fetch_out_inst (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.lookup_fire (lookup_fire),
		.way_hit     (way_hit),
		.word_sel    (addr[3:2]),
		.rdata0      (rdata0),
		.rdata1      (rdata1),
		.rdata2      (rdata2),
		.rdata3      (rdata3),
		.inst        (inst),
		.ready       (ready)
	);

endmodule

//--- run.sh
#!/bin/bash
# build and run the icache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f all.f --top-module icache_tb -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
if ! grep -q "No errors" sim.log; then
	echo "simulation did not complete"
	exit 1
fi

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
	parameter logic [31:0] MEM_MULT = 32'h9e37_79b1,
	parameter logic [31:0] MEM_PATTERN = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        gaps_en,
	input  logic [31:0] araddr,
	input  logic [7:0]  arlen,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready
);

	integer seed;
	// a burst is in progress
	logic busy;
	// handshakes that complete on the coming rising edge
	logic ar_hs;
	logic r_hs;
	// byte address of the beat on the bus, and beats still to send after it
	logic [31:0] beat_addr;
	logic [7:0] beats_left;

	// 32-bit word stored at a word aligned byte address
	function automatic logic [31:0] word_at(input logic [31:0] w);
		return (w * MEM_MULT) ^ MEM_PATTERN;
	endfunction

	initial begin
		seed = 75;
		busy = 1'b0;
		ar_hs = 1'b0;
		r_hs = 1'b0;
		beat_addr = '0;
		beats_left = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		rresp = 2'b00;
	end

	always begin
		// channel signals are stable by the falling edge
		@(negedge clk);
		ar_hs = arvalid && arready;
		r_hs = rvalid && rready;
		// outputs change 2 ns after the rising edge, like the rest of the stimulus
		@(posedge clk);
		#2;
		if (rst) begin
			busy = 1'b0;
			arready = 1'b0;
			rvalid = 1'b0;
			rlast = 1'b0;
		end else begin
			if (ar_hs) begin
				busy = 1'b1;
				beat_addr = {araddr[31:3], 3'b000};
				beats_left = arlen;
			end else if (r_hs) begin
				if (rlast) begin
					busy = 1'b0;
				end else begin
					// INCR burst of 8-byte beats
					beat_addr = beat_addr + 32'd8;
					beats_left = beats_left - 8'd1;
				end
			end
			// one outstanding burst at a time
			arready = !busy && (!gaps_en || (($random(seed) & 1) != 0));
			if (!busy) begin
				rvalid = 1'b0;
			end else if (!(rvalid && !r_hs)) begin
				// roughly one gap in four beats
				rvalid = !gaps_en || (($random(seed) & 3) != 0);
			end
			rlast = rvalid && (beats_left == 8'd0);
			// little endian, lower word at the lower address
			rdata = {word_at(beat_addr + 32'd4), word_at(beat_addr)};
		end
	end

endmodule

//--- tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

	// memory contents are a fixed function of the word address
	localparam logic [31:0] MEM_MULT = 32'h9e37_79b1;
	localparam logic [31:0] MEM_PATTERN = 32'h5a0f_c3a5;
	localparam int DRIVE_DLY = 2;
	// cycles allowed for one fetch, covers a slow burst
	localparam int FETCH_TIMEOUT = 400;

	logic        clk;
	logic        rst;
	logic [63:0] addr;
	logic        valid;
	logic        flush;
	logic        inv_valid;
	logic [63:0] inv_addr;
	logic [31:0] inst;
	logic        ready;
	logic        hit_out;
	logic [31:0] araddr;
	logic [7:0]  arlen;
	logic [2:0]  arsize;
	logic [1:0]  arburst;
	logic        arvalid;
	logic        arready;
	logic [63:0] rdata;
	logic [1:0]  rresp;
	logic        rlast;
	logic        rvalid;
	logic        rready;
	logic        gaps_en;

	integer seed;
	// byte address of the fetch in flight
	logic [31:0] exp_addr;
	// set once a wait runs out, later steps are skipped
	logic abort;
	// request seen without arready at the previous falling edge
	logic ar_waiting;
	logic [31:0] ar_held;

	int ar_count;
	int result_count;
	int inst_fails;
	int ar_fails;
	int seq_fails;
	int timeouts;

	icache_top icache_top_inst (
		.clk (clk), .rst (rst), .addr (addr), .valid (valid), .flush (flush),
		.inv_valid (inv_valid), .inv_addr (inv_addr), .inst (inst), .ready (ready),
		.hit_out (hit_out), .araddr (araddr), .arlen (arlen), .arsize (arsize),
		.arburst (arburst), .arvalid (arvalid), .arready (arready), .rdata (rdata),
		.rresp (rresp), .rlast (rlast), .rvalid (rvalid), .rready (rready)
	);

	axi_mem_model #(.MEM_MULT (MEM_MULT), .MEM_PATTERN (MEM_PATTERN)) axi_mem_inst (
		.clk (clk), .rst (rst), .gaps_en (gaps_en), .araddr (araddr), .arlen (arlen),
		.arvalid (arvalid), .arready (arready), .rdata (rdata), .rresp (rresp),
		.rlast (rlast), .rvalid (rvalid), .rready (rready)
	);

	// instruction expected at a byte address
	function automatic logic [31:0] ref_inst(input logic [31:0] a);
		logic [31:0] w;
		w = {a[31:2], 2'b00};
		return (w * MEM_MULT) ^ MEM_PATTERN;
	endfunction

	always #20 clk = ~clk;

	// every returned instruction against the reference
	always @(negedge clk) begin
		if (!rst && ready) begin
			result_count++;
			if (inst !== ref_inst(exp_addr)) begin
				inst_fails++;
				$display("mismatch at %0t: inst expected %h got %h", $time,
					ref_inst(exp_addr), inst);
			end
		end
	end

	// read channel monitor, counts bursts
	always @(negedge clk) begin
		if (rst) begin
			ar_waiting = 1'b0;
		end else begin
			if (ar_waiting && (arvalid !== 1'b1 || araddr !== ar_held)) begin
				ar_fails++;
				$display("%0t: read request dropped or changed before it was accepted", $time);
			end
			if (arvalid && arready) begin
				ar_count++;
				if (araddr !== {exp_addr[31:6], 6'd0}) begin
					ar_fails++;
					$display("mismatch at %0t: araddr expected %h got %h", $time,
						{exp_addr[31:6], 6'd0}, araddr);
				end
				if (arlen !== 8'd7) begin
					ar_fails++;
					$display("mismatch at %0t: arlen expected 7 got %0d", $time, arlen);
				end
				if (arsize !== 3'd3) begin
					ar_fails++;
					$display("mismatch at %0t: arsize expected 3 got %0d", $time, arsize);
				end
				if (arburst !== 2'd1) begin
					ar_fails++;
					$display("mismatch at %0t: arburst expected 1 got %0d", $time, arburst);
				end
			end
			// the cache takes every beat it is offered
			if (rvalid && rready !== 1'b1) begin
				ar_fails++;
				$display("mismatch at %0t: rready expected 1 got %b", $time, rready);
			end
			ar_waiting = arvalid && !arready;
			ar_held = araddr;
		end
	end

	task automatic next_drive_point();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// hold valid and addr until ready, a hit must answer after exactly one cycle
	task automatic fetch(input logic [31:0] a, input logic hit_expected);
		int n;
		if (abort) return;
		next_drive_point();
		addr = {32'h0, a};
		exp_addr = a;
		valid = 1'b1;
		@(negedge clk);
		if (hit_expected && hit_out !== 1'b1) begin
			seq_fails++;
			$display("mismatch at %0t: hit_out expected 1 got %b", $time, hit_out);
		end
		n = 0;
		while (ready !== 1'b1 && n < FETCH_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (ready !== 1'b1) begin
			timeouts++;
			abort = 1'b1;
			$display("%0t: timeout, no ready for fetch of %h", $time, a);
		end else if (hit_expected && n != 1) begin
			seq_fails++;
			$display("mismatch at %0t: ready latency expected 1 got %0d", $time, n);
		end
		next_drive_point();
		valid = 1'b0;
	endtask

	task automatic check_bursts(input int expected);
		if (!abort && ar_count != expected) begin
			seq_fails++;
			$display("mismatch at %0t: burst count expected %0d got %0d", $time,
				expected, ar_count);
		end
	endtask

	// one cycle store-side snoop
	task automatic snoop(input logic [31:0] a);
		next_drive_point();
		inv_valid = 1'b1;
		inv_addr = {32'h0, a};
		next_drive_point();
		inv_valid = 1'b0;
	endtask

	// flush together with a hit, the result must not come out
	task automatic flush_hit(input logic [31:0] a);
		if (abort) return;
		next_drive_point();
		addr = {32'h0, a};
		exp_addr = a;
		valid = 1'b1;
		flush = 1'b1;
		@(negedge clk);
		if (hit_out !== 1'b1) begin
			seq_fails++;
			$display("%0t: flush test address %h did not hit", $time, a);
		end
		next_drive_point();
		valid = 1'b0;
		flush = 1'b0;
		@(negedge clk);
		if (ready !== 1'b0) begin
			seq_fails++;
			$display("mismatch at %0t: ready expected 0 got %b", $time, ready);
		end
	endtask

	initial begin
		int bursts;
		logic [31:0] base;
		logic [31:0] line;
		logic [31:0] saved [12];
		seed = 75;
		clk = 1'b0;
		rst = 1'b1;
		addr = '0;
		valid = 1'b0;
		flush = 1'b0;
		inv_valid = 1'b0;
		inv_addr = '0;
		gaps_en = 1'b0;
		exp_addr = '0;
		abort = 1'b0;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		@(negedge clk);
		if (ready !== 1'b0 || arvalid !== 1'b0) begin
			seq_fails++;
			$display("%0t: ready or arvalid high after reset", $time);
		end

		// cold miss, then every word of the filled line hits
		base = 32'h0000_1200;
		bursts = ar_count;
		fetch(base + 32'h34, 1'b0);
		check_bursts(bursts + 1);
		bursts = ar_count;
		for (int i = 0; i < 16; i++) begin
			fetch(base + 32'(i * 4), 1'b1);
		end
		check_bursts(bursts);

		// five tags in one set, four ways
		line = 32'h0004_0280;
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < 5; k++) begin
				fetch(line + (32'(k) << 10) + 32'(k * 4 + 8), 1'b0);
			end
		end

		// snoop kills the line, one new burst refills it
		fetch(base + 32'h10, 1'b1);
		snoop(base + 32'h38);
		bursts = ar_count;
		fetch(base + 32'h10, 1'b0);
		check_bursts(bursts + 1);

		flush_hit(base + 32'h08);

		// random arready and rvalid gaps
		gaps_en = 1'b1;
		for (int i = 0; i < 12; i++) begin
			saved[i] = $random(seed) & 32'h0000_fffc;
			fetch(saved[i], 1'b0);
		end
		for (int i = 0; i < 12; i++) begin
			fetch(saved[i], 1'b0);
		end

		$write("results %0d, bursts %0d, inst mismatches %0d, ",
			result_count, ar_count, inst_fails);
		$display("read channel failures %0d, sequence failures %0d, timeouts %0d",
			ar_fails, seq_fails, timeouts);
		if (inst_fails == 0 && ar_fails == 0 && seq_fails == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
